/* verilog.f */
src/fpn_pkg.sv
src/fpn_bus_port.sv
src/fpn_lead_detect.sv
src/fpn_shift_norm.sv
src/fpn_round_rne.sv
src/fpn_norm_top.sv
bench/fpn_norm_sva.sv
bench/fpn_norm_tb.sv

/* Makefile */
# Verilator build, run, lint and clean for the normalization stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module fpn_norm_tb

run: build
	@out="$$(./obj_dir/Vfpn_norm_tb)"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module fpn_norm_top

clean:
	rm -rf obj_dir

/* bench/fpn_norm_tb.sv */
`timescale 1ns/1ps

module fpn_norm_tb import fpn_pkg::*; ();

    // bounds for every wait loop, in clock cycles and in read polls
    localparam int ACK_LIMIT = 16;
    localparam int POLL_LIMIT = 16;

    logic             i_clk = 1'b0;
    logic             i_rst = 1'b1;
    logic             i_wb_cyc = 1'b0;
    logic             i_wb_stb = 1'b0;
    logic             i_wb_we = 1'b0;
    logic             i_wb_adr = 1'b0;
    logic [WB_DW-1:0] i_wb_dat = '0;
    logic [WB_DW-1:0] o_wb_dat;
    logic             o_wb_ack;

    logic [15:0]      lfsr = 16'd45677;
    int               checks = 0;
    int               mismatches = 0;
    int               timeouts = 0;

    fpn_norm_top u_fpn_norm_top (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack)
    );

    always #5 i_clk = ~i_clk;

    // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit, the newest bit shifts in at the bottom
    task automatic draw_bits(input int n, output logic [SUM_W-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[SUM_W-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [SUM_W-1:0] negate(input logic [SUM_W-1:0] v);
        negate = ~v + SUM_W'(1);
    endfunction

    // expected read word built straight from the normalization and rounding rules
    function automatic logic [WB_DW-1:0] expected_word(input logic [SUM_W-1:0] sum);
        logic        sign;
        logic [17:0] mag;
        int          p;
        logic [10:0] mant;
        logic [4:0]  exp_chg;
        logic        rnd;
        logic        sticky;
        logic        inc;
        logic [11:0] rounded;
        logic        carry;
        logic [WB_DW-1:0] word;
        sign = sum[SUM_W-1];
        mag = sign ? 18'(negate(sum)) : sum[17:0];
        // p stays negative when bits 17..3 are all clear
        p = -1;
        for (int i = 3; i <= 17; i++) begin
            if (mag[i]) begin
                p = i;
            end
        end
        mant = '0;
        exp_chg = '0;
        rnd = 1'b0;
        sticky = 1'b0;
        if (p >= 0) begin
            // mantissa bit 10-k takes magnitude bit p-k, zeros below bit 0
            for (int k = 0; k < 11; k++) begin
                if (p - k >= 0) begin
                    mant[10 - k] = mag[p - k];
                end
            end
            exp_chg = 5'(p - 13);
            if (p >= 11) begin
                rnd = mag[p - 11];
            end
            for (int i = 0; i < 18; i++) begin
                if (i <= p - 12) begin
                    sticky = sticky | mag[i];
                end
            end
        end
        // nearest even, mantissa bit 0 acts as the guard
        inc = rnd & (mant[0] | sticky);
        rounded = {1'b0, mant} + {11'b0, inc};
        carry = rounded[11];
        word = '0;
        word[RD_MANT_LSB +: 11] = carry ? rounded[11:1] : rounded[10:0];
        word[RD_EXP_LSB +: 5] = exp_chg;
        word[RD_CARRY_BIT] = carry;
        word[RD_SIGN_BIT] = sign;
        word[RD_VALID_BIT] = 1'b1;
        expected_word = word;
    endfunction

    // one classic cycle, inputs change only on the falling edge and ack is sampled there
    task automatic bus_access(input logic we, input logic adr, input logic [WB_DW-1:0] wdata,
                              output logic [WB_DW-1:0] rdata);
        int wait_cycles;
        @(negedge i_clk);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we = we;
        i_wb_adr = adr;
        i_wb_dat = wdata;
        wait_cycles = 0;
        @(negedge i_clk);
        while (!o_wb_ack && wait_cycles < ACK_LIMIT) begin
            @(negedge i_clk);
            wait_cycles++;
        end
        if (!o_wb_ack) begin
            timeouts++;
            $display("timeout at %0t: the slave never acked the bus cycle", $time);
        end
        rdata = o_wb_dat;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we = 1'b0;
    endtask

    // write a sum, poll until valid, compare, then confirm the flag cleared on read
    task automatic check_sum(input logic [SUM_W-1:0] sum);
        logic [WB_DW-1:0] got;
        logic [WB_DW-1:0] want;
        int               polls;
        want = expected_word(sum);
        bus_access(1'b1, ADDR_SUM, WB_DW'(sum), got);
        got = '0;
        polls = 0;
        while (!got[RD_VALID_BIT] && polls < POLL_LIMIT) begin
            bus_access(1'b0, ADDR_RES, '0, got);
            polls++;
        end
        if (!got[RD_VALID_BIT]) begin
            timeouts++;
            $display("timeout at %0t: the result for sum %05h never became valid", $time, sum);
        end else begin
            checks++;
            assert (got == want) else begin
                mismatches++;
                $display("MISMATCH at %0t: sum %05h read %08h expected %08h",
                         $time, sum, got, want);
            end
            bus_access(1'b0, ADDR_RES, '0, got);
            checks++;
            assert (!got[RD_VALID_BIT]) else begin
                mismatches++;
                $display("MISMATCH at %0t: valid still set on the read after a read", $time);
            end
        end
    endtask

    initial begin
        logic [SUM_W-1:0] s;
        logic [SUM_W-1:0] burst [3];
        logic [WB_DW-1:0] got;
        repeat (10) @(negedge i_clk);
        i_rst = 1'b0;

        // exponent changes of -3, 4 and -10, then their negatives
        check_sum(19'h00400);
        check_sum(19'h20000);
        check_sum(19'h00008);
        check_sum(negate(19'h00400));
        check_sum(negate(19'h20000));
        check_sum(negate(19'h00008));
        for (int i = 0; i < 10; i++) begin
            draw_bits(18, s);
            check_sum(negate(s | 19'd1));
        end

        // p=17 with guard round sticky of 011, 110, 010 and an all-ones carry case
        check_sum(19'h20041);
        check_sum(19'h200C0);
        check_sum(19'h20040);
        check_sum(19'h3FFC1);

        // magnitudes below 8 normalize to zero
        for (int i = 0; i < 8; i++) begin
            check_sum(SUM_W'(i));
            check_sum(negate(SUM_W'(i)));
        end

        for (int i = 0; i < 200; i++) begin
            draw_bits(SUM_W, s);
            check_sum(s);
        end

        // three writes in a row, the last result overwrites the earlier two
        for (int i = 0; i < 3; i++) begin
            draw_bits(SUM_W, burst[i]);
            bus_access(1'b1, ADDR_SUM, WB_DW'(burst[i]), got);
        end
        // the third result lands on the fourth rising edge after its ack
        repeat (4) @(posedge i_clk);
        bus_access(1'b0, ADDR_RES, '0, got);
        checks++;
        assert (got == expected_word(burst[2])) else begin
            mismatches++;
            $display("MISMATCH at %0t: burst read %08h expected %08h",
                     $time, got, expected_word(burst[2]));
        end

        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* bench/fpn_norm_sva.sv */
`timescale 1ns/1ps

module fpn_norm_sva (
    input logic i_clk,
    input logic i_rst,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic i_wb_ack
);

    // ack is a single-cycle pulse
    ack_single_pulse: assert property (
        @(posedge i_clk) disable iff (i_rst) i_wb_ack |=> !i_wb_ack
    ) else $error("ack stayed high for two cycles");

    // every ack answers a request seen on the previous edge
    ack_after_request: assert property (
        @(posedge i_clk) disable iff (i_rst) i_wb_ack |-> $past(i_wb_cyc && i_wb_stb)
    ) else $error("ack raised without cyc and stb in the cycle before");

    // reset clears the registered ack
    ack_low_after_reset: assert property (
        @(posedge i_clk) i_rst |=> !i_wb_ack
    ) else $error("ack high in the cycle after reset");

endmodule

bind fpn_norm_top fpn_norm_sva u_fpn_norm_sva (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_ack (o_wb_ack)
);

/* src/fpn_norm_top.sv */
`timescale 1ns/1ps

module fpn_norm_top import fpn_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_wb_cyc,
    input  logic             i_wb_stb,
    input  logic             i_wb_we,
    input  logic             i_wb_adr,
    input  logic [WB_DW-1:0] i_wb_dat,
    output logic [WB_DW-1:0] o_wb_dat,
    output logic             o_wb_ack
);

    logic             start;
    logic [SUM_W-1:0] sum;
    lead_t            lead;
    norm_t            norm;
    result_t          result;

    // bus side, sum capture and the result register
    fpn_bus_port u_fpn_bus_port (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .o_start  (start),
        .o_sum    (sum),
        .i_result (result)
    );

    // three pipeline stages, one cycle each
    fpn_lead_detect u_fpn_lead_detect (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (start),
        .i_sum   (sum),
        .o_lead  (lead)
    );

    fpn_shift_norm u_fpn_shift_norm (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_lead (lead),
        .o_norm (norm)
    );

    fpn_round_rne u_fpn_round_rne (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_norm   (norm),
        .o_result (result)
    );

endmodule

/* src/fpn_round_rne.sv */
`timescale 1ns/1ps

module fpn_round_rne import fpn_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst,
    input  norm_t   i_norm,
    output result_t o_result
);

    logic              guard;
    logic              inc;
    logic [MANT_W:0]   rounded;
    logic              carry;
    logic [MANT_W-1:0] final_mant;

    // guard is the lowest kept mantissa bit
    assign guard = i_norm.mant[0];

    // round to nearest even
    // above half rounds up, exactly half rounds up only when the guard is odd
    assign inc = i_norm.rnd & (guard | i_norm.sticky);

    // one extra bit catches the carry out of an all-ones mantissa
    assign rounded = {1'b0, i_norm.mant} + {{MANT_W{1'b0}}, inc};

    assign carry = rounded[MANT_W];

    // on carry the leading one moves up a place, so shift right by one to renormalize
    assign final_mant = carry ? rounded[MANT_W:1] : rounded[MANT_W-1:0];

    // stage 3 register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_result.valid <= 1'b0;
        end else begin
            o_result.valid <= i_norm.valid;
            o_result.sign <= i_norm.sign;
            o_result.mant <= final_mant;
            // the exponent change passes through, the carry is flagged separately
            o_result.exp_diff <= i_norm.exp_diff;
            o_result.carry <= carry;
        end
    end

endmodule

/* src/fpn_shift_norm.sv */
`timescale 1ns/1ps

module fpn_shift_norm import fpn_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst,
    input  lead_t i_lead,
    output norm_t o_norm
);

    // magnitude with zeros appended below bit 0 for small leading-one positions
    logic [MAG_W+MANT_W-2:0]  ext;
    logic [MANT_W-1:0]        mant;
    logic signed [EXP_W-1:0]  exp_diff;
    logic                     rnd;
    logic                     sticky;

    assign ext = {i_lead.mag, {(MANT_W-1){1'b0}}};

    always_comb begin
        int p;
        p = int'(i_lead.idx) + LEAD_LSB;
        mant = '0;
        exp_diff = '0;
        rnd = 1'b0;
        sticky = 1'b0;
        if (i_lead.found) begin
            // magnitude bit p lands on mantissa bit 10
            mant = ext[p + MANT_W - 1 -: MANT_W];
            // positive means the point moved left
            exp_diff = EXP_W'(p - NORM_POS);
            // round is the first bit below the mantissa, sticky ORs everything under it
            for (int i = 0; i < MAG_W; i++) begin
                if (i + MANT_W == p) begin
                    rnd = i_lead.mag[i];
                end
                if (i + MANT_W + 1 <= p) begin
                    sticky = sticky | i_lead.mag[i];
                end
            end
        end
    end

    // stage 2 register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_norm.valid <= 1'b0;
        end else begin
            o_norm.valid <= i_lead.valid;
            o_norm.sign <= i_lead.sign;
            o_norm.mant <= mant;
            o_norm.exp_diff <= exp_diff;
            o_norm.rnd <= rnd;
            o_norm.sticky <= sticky;
        end
    end

endmodule

/* src/fpn_lead_detect.sv */
`timescale 1ns/1ps

module fpn_lead_detect import fpn_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_start,
    input  logic [SUM_W-1:0] i_sum,
    output lead_t            o_lead
);

    logic             sign;
    logic [SUM_W-1:0] abs_sum;
    logic [MAG_W-1:0] mag;
    logic [IDX_W-1:0] idx;
    logic             found;

    // the top bit of the two's-complement sum is the sign
    assign sign = i_sum[SUM_W-1];

    // negate negative sums to get the magnitude
    assign abs_sum = sign ? (~i_sum + 1'b1) : i_sum;

    // the most negative sum overflows into bit 18 and leaves a zero magnitude
    assign mag = abs_sum[MAG_W-1:0];

    // priority search for the highest set bit among magnitude bits 17..3
    // the loop runs upward so a higher bit overrides a lower one
    always_comb begin
        idx = '0;
        found = 1'b0;
        for (int i = 0; i < LEAD_W; i++) begin
            if (mag[i + LEAD_LSB]) begin
                idx = IDX_W'(i);
                found = 1'b1;
            end
        end
    end

    // bits 2..0 alone never set found, those sums normalize to zero

    // stage 1 register, valid follows start by one cycle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_lead.valid <= 1'b0;
        end else begin
            o_lead.valid <= i_start;
            o_lead.sign <= sign;
            o_lead.mag <= mag;
            o_lead.idx <= idx;
            o_lead.found <= found;
        end
    end

endmodule

/* src/fpn_bus_port.sv */
`timescale 1ns/1ps

module fpn_bus_port import fpn_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_wb_cyc,
    input  logic             i_wb_stb,
    input  logic             i_wb_we,
    input  logic             i_wb_adr,
    input  logic [WB_DW-1:0] i_wb_dat,
    output logic [WB_DW-1:0] o_wb_dat,
    output logic             o_wb_ack,
    output logic             o_start,
    output logic [SUM_W-1:0] o_sum,
    input  result_t          i_result
);

    logic             req;
    logic             wr_hit;
    logic             rd_hit;
    result_t          res_q;
    logic [WB_DW-1:0] rd_word;

    // a new request is one the slave has not acked yet
    assign req = i_wb_cyc & i_wb_stb & ~o_wb_ack;
    assign wr_hit = req & i_wb_we & (i_wb_adr == ADDR_SUM);
    assign rd_hit = req & ~i_wb_we;

    // ack is a single-cycle pulse, so the master must drop stb before the next request
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_ack <= 1'b0;
            o_start <= 1'b0;
        end else begin
            o_wb_ack <= req;
            // start lines up with the ack edge and feeds stage 1 directly
            o_start <= wr_hit;
        end
    end

    // the sum is held at the stage 1 input until the next write
    always_ff @(posedge i_clk) begin
        if (wr_hit) begin
            o_sum <= i_wb_dat[SUM_W-1:0];
        end
    end

    // result register, its valid field doubles as the clear-on-read flag
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            res_q.valid <= 1'b0;
        end else if (i_result.valid) begin
            // a fresh result wins over a read clear in the same cycle
            res_q <= i_result;
        end else if (rd_hit && (i_wb_adr == ADDR_RES)) begin
            res_q.valid <= 1'b0;
        end
    end

    // read mux, the result word at the result address and zero elsewhere
    always_comb begin
        rd_word = '0;
        if (i_wb_adr == ADDR_RES) begin
            rd_word[RD_MANT_LSB +: MANT_W] = res_q.mant;
            rd_word[RD_EXP_LSB +: EXP_W] = res_q.exp_diff;
            rd_word[RD_CARRY_BIT] = res_q.carry;
            rd_word[RD_SIGN_BIT] = res_q.sign;
            rd_word[RD_VALID_BIT] = res_q.valid;
        end
    end

    // read data is captured at the edge that raises ack, before the flag clears
    always_ff @(posedge i_clk) begin
        if (rd_hit) begin
            o_wb_dat <= rd_word;
        end
    end

endmodule

/* src/fpn_pkg.sv */
package fpn_pkg;

    // the input is a 19-bit two's-complement significand sum
    localparam int SUM_W = 19;
    // magnitude drops the sign bit
    localparam int MAG_W = SUM_W - 1;
    // normalized mantissa including the hidden leading one at bit 10
    localparam int MANT_W = 11;
    // signed exponent change, range -10..4
    localparam int EXP_W = 5;

    // leading one is searched over magnitude bits 17 down to 3
    localparam int LEAD_W = 15;
    localparam int LEAD_LSB = 3;
    localparam int IDX_W = 4;
    // a leading one at this magnitude bit needs no exponent change
    localparam int NORM_POS = 13;

    localparam int WB_DW = 32;

    // word addresses on the 1-bit bus address
    localparam logic ADDR_SUM = 1'b0;
    localparam logic ADDR_RES = 1'b1;

    // field positions in the result read word
    localparam int RD_MANT_LSB = 0;
    localparam int RD_EXP_LSB = 11;
    localparam int RD_CARRY_BIT = 16;
    localparam int RD_SIGN_BIT = 17;
    localparam int RD_VALID_BIT = 31;

    // stage 1 output, idx holds the leading-one position minus 3
    typedef struct packed {
        logic             valid;
        logic             sign;
        logic [MAG_W-1:0] mag;
        logic [IDX_W-1:0] idx;
        logic             found;
    } lead_t;

    // stage 2 output, mantissa aligned with its leading one at bit 10
    typedef struct packed {
        logic                    valid;
        logic                    sign;
        logic [MANT_W-1:0]       mant;
        logic signed [EXP_W-1:0] exp_diff;
        logic                    rnd;
        logic                    sticky;
    } norm_t;

    // stage 3 output after rounding
    typedef struct packed {
        logic                    valid;
        logic                    sign;
        logic [MANT_W-1:0]       mant;
        logic signed [EXP_W-1:0] exp_diff;
        logic                    carry;
    } result_t;

endpackage
